/* rtl/core_pkg.sv */
//--------------------------------------------------------------------
// core-wide widths and word types
// register file size and run state encoding
//--------------------------------------------------------------------

package core_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // only two states: stopped or stepping the pipeline
    typedef enum logic
    {
        IDLE = 1'b0,
        RUN  = 1'b1
    } run_state_e;

endpackage

/* rtl/isa_pkg.sv */
//--------------------------------------------------------------------
// instruction set definitions
// opcode encoding, field widths and the two views of an instruction
//--------------------------------------------------------------------

package isa_pkg;

    import core_pkg::*;

    localparam int OPCODE_W = 5;
    localparam int IMM_W    = 8;
    localparam int VAL_W    = 4;

    // unlisted codes fall through as nop
    typedef enum logic [OPCODE_W-1:0]
    {
        NOP   = 5'd0,
        HALT  = 5'd1,
        LOAD  = 5'd2,
        STORE = 5'd3,
        LDIH  = 5'd4,
        ADD   = 5'd5,
        ADDI  = 5'd6,
        ADDC  = 5'd7,
        SUB   = 5'd8,
        SUBI  = 5'd9,
        SUBC  = 5'd10,
        CMP   = 5'd11,
        AND   = 5'd12,
        OR    = 5'd13,
        XOR   = 5'd14,
        SLL   = 5'd15,
        SRL   = 5'd16,
        SRA   = 5'd17,
        SET   = 5'd18,
        JUMP  = 5'd19,
        BZ    = 5'd20,
        BNZ   = 5'd21,
        BN    = 5'd22,
        BNN   = 5'd23,
        BC    = 5'd24,
        BNC   = 5'd25
    } opcode_e;

    // register form; r3 is the low bits of val4
    typedef struct packed
    {
        opcode_e          opcode;
        reg_idx_t         r1;
        logic             spare;
        reg_idx_t         r2;
        logic [VAL_W-1:0] val4;
    } reg_view_t;

    // immediate form
    typedef struct packed
    {
        opcode_e          opcode;
        reg_idx_t         r1;
        logic [IMM_W-1:0] imm8;
    } imm_view_t;

    typedef union packed
    {
        reg_view_t r;
        imm_view_t i;
    } instr_u;

    localparam instr_u NOP_INSTR = '0;

endpackage

/* rtl/run_control.sv */
//--------------------------------------------------------------------
// run controller
// idle/run state machine, pipeline advance and the nxt pulse
//--------------------------------------------------------------------

module run_control
    import core_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic start,
    input  logic wb_halt,
    output logic run,
    output logic nxt
);

    run_state_e state;
    run_state_e state_next;
    logic       stop;

    // enable low or halt in writeback ends the run
    assign stop = !enable || wb_halt;
    assign nxt  = (state == RUN) && stop;

    // the stopping cycle freezes too, so a halt stays in writeback
    assign run  = (state == RUN) && !stop;

    always_comb
    begin
        case (state)
            IDLE:    state_next = (start && enable) ? RUN : IDLE;
            RUN:     state_next = stop ? IDLE : RUN;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_next;
    end

endmodule

/* rtl/fetch_decode.sv */
//--------------------------------------------------------------------
// fetch and decode stages
// program counter, decode register, register file
// operand selection into the execute registers
//--------------------------------------------------------------------

module fetch_decode
    import core_pkg::*, isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,
    input  word_t    i_datain,
    input  logic     branch_taken,
    input  addr_t    branch_target,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output addr_t    i_addr,
    output instr_u   ex_instr,
    output word_t    op_a,
    output word_t    op_b,
    output word_t    store_data
);

    addr_t    pc;
    instr_u   id_ir;
    word_t    gr [REG_COUNT];
    reg_idx_t r3;
    word_t    op_a_next;
    word_t    op_b_next;

    assign i_addr = pc;

    //--------------------------------------------------------------------
    // fetch
    //--------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= '0;
            id_ir <= NOP_INSTR;
        end
        else if (run)
        begin
            id_ir <= i_datain;
            if (branch_taken)
                pc <= branch_target;
            else
                pc <= pc + addr_t'(1);
        end
    end

    // register file, written from writeback
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                gr[i] <= '0;
        end
        else if (run && wr_en)
            gr[wr_idx] <= wr_data;
    end

    //--------------------------------------------------------------------
    // decode
    //--------------------------------------------------------------------
    assign r3 = id_ir.r.val4[REG_IDX_W-1:0];

    always_comb
    begin
        case (id_ir.i.opcode)
            LDIH, ADDI, SUBI, BZ, BNZ, BN, BNN, BC, BNC:
                op_a_next = gr[id_ir.i.r1];
            LOAD, STORE, ADD, ADDC, SUB, SUBC, CMP, AND, OR, XOR, SLL, SRL, SRA:
                op_a_next = gr[id_ir.r.r2];
            // jump target is imm8 plus zero
            default:
                op_a_next = '0;
        endcase
    end

    always_comb
    begin
        case (id_ir.i.opcode)
            LOAD, STORE, SLL, SRL, SRA:
                op_b_next = word_t'(id_ir.r.val4);
            ADDI, SUBI, SET, JUMP, BZ, BNZ, BN, BNN, BC, BNC:
                op_b_next = word_t'(id_ir.i.imm8);
            LDIH:
                op_b_next = {id_ir.i.imm8, {IMM_W{1'b0}}};
            ADD, ADDC, SUB, SUBC, CMP, AND, OR, XOR:
                op_b_next = gr[r3];
            default:
                op_b_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_instr <= NOP_INSTR;
        else if (run)
            ex_instr <= id_ir;
    end

    always_ff @(posedge clk)
    begin
        if (run)
        begin
            op_a       <= op_a_next;
            op_b       <= op_b_next;
            store_data <= gr[id_ir.i.r1];
        end
    end

endmodule

/* rtl/arith_unit.sv */
//--------------------------------------------------------------------
// arithmetic unit
// 17-bit add/subtract with carry and borrow
//--------------------------------------------------------------------

module arith_unit
    import core_pkg::*, isa_pkg::*;
(
    input  opcode_e opcode,
    input  word_t   a,
    input  word_t   b,
    input  logic    carry_in,
    output word_t   sum,
    output logic    carry_out
);

    logic [WORD_W:0] full;
    logic [WORD_W:0] cin_ext;

    assign cin_ext = {{WORD_W{1'b0}}, carry_in};

    always_comb
    begin
        case (opcode)
            ADDC:           full = {1'b0, a} + {1'b0, b} + cin_ext;
            SUB, SUBI, CMP: full = {1'b0, a} - {1'b0, b};
            SUBC:           full = {1'b0, a} - {1'b0, b} - cin_ext;
            // ldih, add, addi, plus load/store address and branch target
            default:        full = {1'b0, a} + {1'b0, b};
        endcase
    end

    // top bit is carry, or borrow on subtract
    assign sum       = full[WORD_W-1:0];
    assign carry_out = full[WORD_W];

endmodule

/* rtl/logic_unit.sv */
//--------------------------------------------------------------------
// logic and shift unit
// bitwise ops, shifts by b[3:0], set
//--------------------------------------------------------------------

module logic_unit
    import core_pkg::*, isa_pkg::*;
(
    input  opcode_e opcode,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    clears_carry
);

    logic [VAL_W-1:0] shamt;

    assign shamt = b[VAL_W-1:0];

    always_comb
    begin
        case (opcode)
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            SET:     result = b;
            default: result = '0;
        endcase
    end

    // shifts keep the carry flag as it is
    assign clears_carry = (opcode == AND) || (opcode == OR) || (opcode == XOR);

endmodule

/* rtl/execute_stage.sv */
//--------------------------------------------------------------------
// execute stage
// unit select, zero/negative/carry flags, execute-to-memory registers
//--------------------------------------------------------------------

module execute_stage
    import core_pkg::*, isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   run,
    input  instr_u ex_instr,
    input  word_t  op_a,
    input  word_t  op_b,
    input  word_t  store_data,
    output instr_u mem_instr,
    output word_t  result,
    output word_t  mem_store_data,
    output logic   store_pending,
    output logic   zf,
    output logic   nf,
    output logic   cf
);

    opcode_e op;
    word_t   sum;
    logic    carry_out;
    word_t   logic_res;
    logic    clears_carry;
    logic    use_logic;
    logic    upd_zn;
    logic    upd_c;
    word_t   alu_out;

    assign op = ex_instr.i.opcode;

    arith_unit u_arith
    (
        .opcode    (op),
        .a         (op_a),
        .b         (op_b),
        .carry_in  (cf),
        .sum       (sum),
        .carry_out (carry_out)
    );

    logic_unit u_logic
    (
        .opcode       (op),
        .a            (op_a),
        .b            (op_b),
        .result       (logic_res),
        .clears_carry (clears_carry)
    );

    // which unit owns the opcode, and which flags it touches
    always_comb
    begin
        use_logic = 1'b0;
        upd_zn    = 1'b0;
        upd_c     = 1'b0;
        case (op)
            LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP:
            begin
                upd_zn = 1'b1;
                upd_c  = 1'b1;
            end
            AND, OR, XOR, SLL, SRL, SRA:
            begin
                use_logic = 1'b1;
                upd_zn    = 1'b1;
            end
            SET:
                use_logic = 1'b1;
            default:
                use_logic = 1'b0;
        endcase
    end

    assign alu_out = use_logic ? logic_res : sum;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            zf            <= 1'b0;
            nf            <= 1'b0;
            cf            <= 1'b0;
            mem_instr     <= NOP_INSTR;
            store_pending <= 1'b0;
        end
        else if (run)
        begin
            if (upd_zn)
            begin
                zf <= (alu_out == '0);
                nf <= alu_out[WORD_W-1];
            end
            if (upd_c)
                cf <= carry_out;
            else if (clears_carry)
                cf <= 1'b0;
            mem_instr     <= ex_instr;
            store_pending <= (op == STORE);
        end
    end

    always_ff @(posedge clk)
    begin
        if (run)
        begin
            result         <= alu_out;
            mem_store_data <= store_data;
        end
    end

endmodule

/* rtl/memory_writeback.sv */
//--------------------------------------------------------------------
// memory and writeback stages
// data bus, branch decision, load capture, register write port
//--------------------------------------------------------------------

module memory_writeback
    import core_pkg::*, isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,
    input  instr_u   mem_instr,
    input  word_t    result,
    input  word_t    mem_store_data,
    input  logic     store_pending,
    input  logic     zf,
    input  logic     nf,
    input  logic     cf,
    input  word_t    d_datain,
    output addr_t    d_addr,
    output logic     d_we,
    output word_t    d_dataout,
    output logic     branch_taken,
    output addr_t    branch_target,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output logic     wb_halt
);

    opcode_e mem_op;
    opcode_e wb_op;
    instr_u  wb_instr;
    word_t   wb_data;

    assign mem_op = mem_instr.i.opcode;
    assign wb_op  = wb_instr.i.opcode;

    //--------------------------------------------------------------------
    // memory
    //--------------------------------------------------------------------
    assign d_addr        = result[ADDR_W-1:0];
    assign d_dataout     = mem_store_data;
    assign d_we          = store_pending && run;
    assign branch_target = result[ADDR_W-1:0];

    always_comb
    begin
        case (mem_op)
            JUMP:    branch_taken = 1'b1;
            BZ:      branch_taken = zf;
            BNZ:     branch_taken = !zf;
            BN:      branch_taken = nf;
            BNN:     branch_taken = !nf;
            BC:      branch_taken = cf;
            BNC:     branch_taken = !cf;
            default: branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_instr <= NOP_INSTR;
        else if (run)
            wb_instr <= mem_instr;
    end

    // load data arrives in the same cycle as d_addr
    always_ff @(posedge clk)
    begin
        if (run)
            wb_data <= (mem_op == LOAD) ? d_datain : result;
    end

    //--------------------------------------------------------------------
    // writeback
    //--------------------------------------------------------------------
    always_comb
    begin
        case (wb_op)
            LOAD, LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC,
            AND, OR, XOR, SLL, SRL, SRA, SET:
                wr_en = 1'b1;
            default:
                wr_en = 1'b0;
        endcase
    end

    assign wr_idx  = wb_instr.i.r1;
    assign wr_data = wb_data;
    assign wb_halt = (wb_op == HALT);

endmodule

/* rtl/cpu_top.sv */
//--------------------------------------------------------------------
// five-stage pipelined core, top level
// run controller and the stage blocks wired in order
//--------------------------------------------------------------------

module cpu_top
    import core_pkg::*, isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  enable,
    input  logic  start,
    input  word_t i_datain,
    input  word_t d_datain,
    output logic  nxt,
    output addr_t i_addr,
    output addr_t d_addr,
    output logic  d_we,
    output word_t d_dataout
);

    logic     run;
    logic     wb_halt;
    logic     branch_taken;
    addr_t    branch_target;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // decode to execute
    instr_u   ex_instr;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;

    // execute to memory
    instr_u   mem_instr;
    word_t    ex_result;
    word_t    mem_store_data;
    logic     store_pending;
    logic     zf;
    logic     nf;
    logic     cf;

    run_control u_run_control
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .start   (start),
        .wb_halt (wb_halt),
        .run     (run),
        .nxt     (nxt)
    );

    fetch_decode u_fetch_decode
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .i_datain      (i_datain),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .i_addr        (i_addr),
        .ex_instr      (ex_instr),
        .op_a          (op_a),
        .op_b          (op_b),
        .store_data    (store_data)
    );

    execute_stage u_execute
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .run            (run),
        .ex_instr       (ex_instr),
        .op_a           (op_a),
        .op_b           (op_b),
        .store_data     (store_data),
        .mem_instr      (mem_instr),
        .result         (ex_result),
        .mem_store_data (mem_store_data),
        .store_pending  (store_pending),
        .zf             (zf),
        .nf             (nf),
        .cf             (cf)
    );

    memory_writeback u_memory_writeback
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .run            (run),
        .mem_instr      (mem_instr),
        .result         (ex_result),
        .mem_store_data (mem_store_data),
        .store_pending  (store_pending),
        .zf             (zf),
        .nf             (nf),
        .cf             (cf),
        .d_datain       (d_datain),
        .d_addr         (d_addr),
        .d_we           (d_we),
        .d_dataout      (d_dataout),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .wb_halt        (wb_halt)
    );

endmodule

/* dv/cpu_properties.sv */
//----------------------------------------------------------------------
// concurrent checks on the core's top-level ports
// reset quiet period, nxt pulse width, pc hold after a stop
//----------------------------------------------------------------------

module cpu_properties
    import core_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  start,
    input logic  nxt,
    input logic  d_we,
    input addr_t i_addr
);

    // quiet while in reset
    assert property (@(posedge clk) !rst_n |-> (!nxt && !d_we))
        else $error("nxt or d_we high during reset");

    // and in the first cycle after it
    assert property (@(posedge clk) !rst_n |=> (!nxt && !d_we))
        else $error("nxt or d_we high in the cycle after reset");

    // nxt is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) nxt |=> !nxt)
        else $error("nxt high for two cycles");

    // a stopped core keeps its pc until restarted
    assert property (@(posedge clk) disable iff (!rst_n) ($past(nxt) && !start) |-> $stable(i_addr))
        else $error("i_addr moved after nxt");

endmodule

bind cpu_top cpu_properties u_properties
(
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .nxt    (nxt),
    .d_we   (d_we),
    .i_addr (i_addr)
);

/* dv/tb_top.sv */
//----------------------------------------------------------------------
// testbench for the pipelined core
// clock, reset, memories, random program generator
// ISA-level reference model and compare tasks
//----------------------------------------------------------------------

module tb_top
    import core_pkg::*, isa_pkg::*;
();

    localparam int NUM_PROGS   = 25;
    localparam int RAND_BLOCKS = 16;
    localparam int RUN_TIMEOUT = 4000;
    localparam int MAX_PAUSES  = 3;
    localparam int MODEL_STEPS = 1000;

    // arith 0-8, logic 9-14, memory 15-16, control 17-23
    localparam opcode_e OPS [24] = '{LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP, SET,
                                     AND, OR, XOR, SLL, SRL, SRA, LOAD, STORE,
                                     JUMP, BZ, BNZ, BN, BNN, BC, BNC};
    localparam int MODE_LO [5] = '{0, 8, 8, 0, 0};
    localparam int MODE_HI [5] = '{8, 14, 16, 23, 23};

    logic  clk;
    logic  rst_n;
    logic  enable;
    logic  start;
    word_t i_datain;
    word_t d_datain;
    logic  nxt;
    addr_t i_addr;
    addr_t d_addr;
    logic  d_we;
    word_t d_dataout;

    word_t imem [256];
    word_t dmem [256];
    word_t model_mem [256];
    addr_t exp_addr [$];
    word_t exp_data [$];
    int    nxt_count;
    logic  halt_seen;

    cpu_top UUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .start     (start),
        .i_datain  (i_datain),
        .d_datain  (d_datain),
        .nxt       (nxt),
        .i_addr    (i_addr),
        .d_addr    (d_addr),
        .d_we      (d_we),
        .d_dataout (d_dataout)
    );

    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //----------------------------------------------------------------------
    // error reporting and compare tasks
    //----------------------------------------------------------------------
    task automatic stop_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_store(addr_t addr, word_t data);
        addr_t ea;
        word_t ed;
        if (exp_addr.size() == 0)
            stop_run("store on the data bus after the last expected store");
        else
        begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (addr !== ea)
                stop_run($sformatf("FAILED d_addr: got %h expected %h", addr, ea));
            else if (data !== ed)
                stop_run($sformatf("FAILED d_dataout: got %h expected %h", data, ed));
        end
    endtask

    task automatic check_halt(logic halted);
        if (halted !== 1'b1)
            stop_run($sformatf("FAILED nxt on halt: got %h expected %h", halted, 1'b1));
    endtask

    task automatic check_count(string name, int got, int expected);
        if (got != expected)
            stop_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
    endtask

    // bus monitor, also the data memory write port
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (d_we)
            begin
                check_store(d_addr, d_dataout);
                dmem[d_addr] = d_dataout;
            end
            if (nxt)
            begin
                nxt_count = nxt_count + 1;
                if (enable)
                    halt_seen = 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // program generation
    //----------------------------------------------------------------------
    function automatic int rand_below(int n);
        return int'($urandom_range(n - 1, 0));
    endfunction

    function automatic word_t enc_reg(opcode_e op, reg_idx_t r1, reg_idx_t r2,
                                      logic [3:0] val4);
        return {op, r1, 1'b0, r2, val4};
    endfunction

    function automatic word_t enc_imm(opcode_e op, reg_idx_t r1, logic [7:0] imm8);
        return {op, r1, imm8};
    endfunction

    // never picks register 0 as a destination
    function automatic reg_idx_t rand_dst();
        return reg_idx_t'(1 + rand_below(7));
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_below(8));
    endfunction

    function automatic word_t random_instr(int mode, int blk);
        opcode_e    op;
        logic [7:0] target;
        op = OPS[MODE_LO[mode] + rand_below(MODE_HI[mode] - MODE_LO[mode] + 1)];
        // forward branches land on a block start, at most the first store block
        target = 8'((blk + 1 + rand_below(RAND_BLOCKS - blk)) * 4);
        case (op)
            LDIH, ADDI, SUBI, SET:
                return enc_imm(op, rand_dst(), 8'($urandom));
            CMP, STORE:
                return enc_reg(op, rand_reg(), rand_reg(), 4'($urandom));
            JUMP, BZ, BNZ, BN, BNN, BC, BNC:
                return enc_imm(op, 3'd0, target);
            default:
                return enc_reg(op, rand_dst(), rand_reg(), 4'($urandom));
        endcase
    endfunction

    task automatic build_program(int mode);
        word_t v;
        for (int i = 0; i < 256; i++)
        begin
            imem[i]      = '0;
            v            = word_t'($urandom);
            dmem[i]      = v;
            model_mem[i] = v;
        end
        for (int b = 0; b < RAND_BLOCKS; b++)
            imem[b * 4] = random_instr(mode, b);
        for (int r = 1; r < REG_COUNT; r++)
            imem[(RAND_BLOCKS + r - 1) * 4] = enc_reg(STORE, reg_idx_t'(r), 3'd0, 4'(r));
        imem[(RAND_BLOCKS + 7) * 4] = enc_imm(HALT, 3'd0, 8'd0);
    endtask

    //----------------------------------------------------------------------
    // ISA model, fills the expected store queues
    //----------------------------------------------------------------------
    task automatic run_model();
        word_t       gr [REG_COUNT];
        logic        zf;
        logic        nf;
        logic        cf;
        addr_t       pc;
        word_t       w;
        opcode_e     op;
        reg_idx_t    r1;
        reg_idx_t    r2;
        reg_idx_t    r3;
        logic [3:0]  val4;
        logic [7:0]  imm8;
        logic [16:0] full;
        word_t       res;
        addr_t       ea;
        logic        halted;
        logic        taken;
        int          steps;
        for (int i = 0; i < REG_COUNT; i++)
            gr[i] = '0;
        zf     = 1'b0;
        nf     = 1'b0;
        cf     = 1'b0;
        pc     = '0;
        halted = 1'b0;
        steps  = 0;
        while (!halted)
        begin
            if (steps >= MODEL_STEPS)
                stop_run("reference model never reached HALT");
            steps++;
            w     = imem[pc];
            op    = opcode_e'(w[15:11]);
            r1    = w[10:8];
            r2    = w[6:4];
            val4  = w[3:0];
            r3    = val4[2:0];
            imm8  = w[7:0];
            pc    = pc + 8'd1;
            taken = 1'b0;
            full  = {1'b0, gr[r2]} + {13'd0, val4};
            ea    = full[7:0];
            case (op)
                HALT:  halted = 1'b1;
                LOAD:  gr[r1] = model_mem[ea];
                STORE:
                begin
                    model_mem[ea] = gr[r1];
                    exp_addr.push_back(ea);
                    exp_data.push_back(gr[r1]);
                end
                SET:   gr[r1] = {8'd0, imm8};
                JUMP:  pc = imm8;
                BZ:    taken = zf;
                BNZ:   taken = !zf;
                BN:    taken = nf;
                BNN:   taken = !nf;
                BC:    taken = cf;
                BNC:   taken = !cf;
                LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP:
                begin
                    case (op)
                        LDIH:    full = {1'b0, gr[r1]} + {1'b0, imm8, 8'd0};
                        ADD:     full = {1'b0, gr[r2]} + {1'b0, gr[r3]};
                        ADDI:    full = {1'b0, gr[r1]} + {9'd0, imm8};
                        ADDC:    full = {1'b0, gr[r2]} + {1'b0, gr[r3]} + {16'd0, cf};
                        SUB:     full = {1'b0, gr[r2]} - {1'b0, gr[r3]};
                        SUBI:    full = {1'b0, gr[r1]} - {9'd0, imm8};
                        SUBC:    full = {1'b0, gr[r2]} - {1'b0, gr[r3]} - {16'd0, cf};
                        default: full = {1'b0, gr[r2]} - {1'b0, gr[r3]};
                    endcase
                    res = full[15:0];
                    zf  = (res == '0);
                    nf  = res[15];
                    cf  = full[16];
                    if (op != CMP)
                        gr[r1] = res;
                end
                AND, OR, XOR, SLL, SRL, SRA:
                begin
                    case (op)
                        AND:     res = gr[r2] & gr[r3];
                        OR:      res = gr[r2] | gr[r3];
                        XOR:     res = gr[r2] ^ gr[r3];
                        SLL:     res = gr[r2] << val4;
                        SRL:     res = gr[r2] >> val4;
                        default: res = word_t'($signed(gr[r2]) >>> val4);
                    endcase
                    zf = (res == '0);
                    nf = res[15];
                    // bitwise ops clear carry, shifts keep it
                    if (op == AND || op == OR || op == XOR)
                        cf = 1'b0;
                    gr[r1] = res;
                end
                default:
                    taken = 1'b0;
            endcase
            // slots after a branch are nops, so redirect at once
            if (taken)
                pc = gr[r1][7:0] + imm8;
        end
    endtask

    //----------------------------------------------------------------------
    // DUT control
    //----------------------------------------------------------------------
    task automatic reset_dut();
        rst_n  = 1'b0;
        enable = 1'b0;
        start  = 1'b0;
        repeat (4) @(negedge clk);
        rst_n  = 1'b1;
    endtask

    // runs to HALT with random enable drops; returns how many
    task automatic run_program(output int pauses);
        int cycles;
        int idle;
        pauses = 0;
        cycles = 0;
        @(negedge clk);
        enable = 1'b1;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        while (!halt_seen)
        begin
            if (cycles >= RUN_TIMEOUT)
                stop_run("timed out waiting for the core to reach HALT");
            if (pauses < MAX_PAUSES && rand_below(24) == 0)
            begin
                enable = 1'b0;
                pauses++;
                idle   = 1 + rand_below(4);
                repeat (idle) @(negedge clk);
                enable = 1'b1;
                start  = 1'b1;
                @(negedge clk);
                start  = 1'b0;
                cycles = cycles + idle + 1;
            end
            else
            begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    initial
    begin
        int pauses;
        rst_n     = 1'b0;
        enable    = 1'b0;
        start     = 1'b0;
        nxt_count = 0;
        halt_seen = 1'b0;
        void'($urandom(32'ha469));
        for (int p = 0; p < NUM_PROGS; p++)
        begin
            build_program(p % 5);
            exp_addr.delete();
            exp_data.delete();
            run_model();
            reset_dut();
            nxt_count = 0;
            halt_seen = 1'b0;
            run_program(pauses);
            check_count("stores left", exp_addr.size(), 0);
            // a restart with HALT still in writeback stops again at once
            halt_seen = 1'b0;
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            @(negedge clk);
            check_halt(halt_seen);
            check_count("nxt_count", nxt_count, pauses + 2);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* files.f */
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/run_control.sv
rtl/fetch_decode.sv
rtl/arith_unit.sv
rtl/logic_unit.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/cpu_top.sv
dv/cpu_properties.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
